//--- noc_router.f
src/noc_flit_pkg.sv
src/noc_route_pkg.sv
src/route_select.sv
src/output_arbiter.sv
src/router_crossbar.sv
src/noc_router.sv
tb/noc_router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the router testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f noc_router.f --top-module noc_router_tb -o noc_router_sim \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/noc_router_sim)"
echo "$sim_out"
grep -q "TEST PASSED" <<< "$sim_out" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb/noc_router_testdata.txt
# Router position: router <x> <y>
# Test start: test <id> <random out_ready 0 or 1>
# Packet: <source port> <dest x> <dest y> <flits> <payload base hex> <output port>
# Ports: 0 eject, 1 south, 2 west, 3 north, 4 east
router 3 3
test 1 0
0 3 3 1 00001000 0
1 3 3 2 00001100 0
2 3 3 3 00001200 0
3 3 3 1 00001300 0
4 3 3 2 00001400 0
test 2 0
0 3 0 1 00002000 1
0 3 7 1 00002010 3
0 0 3 1 00002020 2
0 7 3 1 00002030 4
1 1 1 1 00002040 2
1 6 1 1 00002050 4
2 1 6 1 00002060 2
2 6 6 1 00002070 4
3 3 2 1 00002080 1
3 3 4 1 00002090 3
4 2 3 1 000020a0 2
4 4 3 1 000020b0 4
1 3 6 1 000020c0 3
3 3 1 1 000020d0 1
test 3 1
1 5 5 4 00003000 4
2 5 0 3 00003100 4
3 0 0 5 00003200 2
4 1 3 4 00003300 2
0 3 6 3 00003400 3
1 3 0 2 00003500 1
2 3 3 4 00003600 0
test 4 0
0 7 2 4 00004000 4
1 6 5 4 00004100 4
2 5 3 4 00004200 4
3 4 0 4 00004300 4
0 7 7 3 00004400 4
2 6 1 2 00004500 4
1 2 2 3 00004600 2
3 0 5 3 00004700 2
4 1 0 3 00004800 2
test 5 1
0 5 6 5 00005000 4
1 3 3 3 00005100 0
2 1 2 4 00005200 2
3 3 0 2 00005300 1
4 3 7 3 00005400 3
0 0 0 2 00005500 2
1 7 7 4 00005600 4
2 3 3 1 00005700 0
3 6 2 3 00005800 4
4 2 6 2 00005900 2

//--- tb/noc_router_tb.sv
/*
 * Testbench for the five-port XY wormhole router
 * Packets come from the test data file and outputs see random back-pressure
 * A scoreboard per output and source checks every delivered flit
 */
module noc_router_tb import noc_flit_pkg::*, noc_route_pkg::*; ();

  localparam int unsigned half_period  = 10;
  localparam int unsigned reset_cycles = 16;
  localparam int unsigned num_tests    = 5;

  // One packet line of the data file
  typedef struct packed {
    logic [3:0]            test_id;
    logic [port_idx_w-1:0] src_port;
    xy_coord_t             dst;
    logic [7:0]            len;
    logic [payload_w-1:0]  base;
    logic [port_idx_w-1:0] exp_port;
  } packet_t;

  logic                      clk;
  logic                      rst_n;
  xy_coord_t                 xy_id;
  flit_t     [num_ports-1:0] in_flit;
  port_vec_t                 in_valid;
  port_vec_t                 in_ready;
  flit_t     [num_ports-1:0] out_flit;
  port_vec_t                 out_valid;
  port_vec_t                 out_ready;

  packet_t     packets[$];
  logic        test_bp[num_tests+1];
  // Flits still to send per input
  flit_t       send_q[num_ports][$];
  // Expected flits indexed by output times num_ports plus source
  flit_t       exp_q[num_ports*num_ports][$];
  int          cur_src[num_ports];
  logic [15:0] lfsr        = 16'd21609;
  int          flit_total  = 0;
  int unsigned wd_cycles   = 0;
  int unsigned check_count = 0;
  int unsigned err_count   = 0;
  int unsigned flit_count  = 0;

  noc_router dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .xy_id_i     (xy_id),
    .in_flit_i   (in_flit),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .out_flit_o  (out_flit),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Fibonacci form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // X is resolved before Y
  function automatic route_dir_e xy_route(input xy_coord_t dst, input xy_coord_t id);
    route_dir_e dir;
    if (dst == id) begin
      dir = eject;
    end else if (dst.x == id.x) begin
      dir = (dst.y < id.y) ? south : north;
    end else begin
      dir = (dst.x < id.x) ? west : east;
    end
    return dir;
  endfunction

  // Position of the node attached to a port
  function automatic xy_coord_t neighbour(input logic [port_idx_w-1:0] port,
                                          input xy_coord_t id);
    xy_coord_t c;
    c = id;
    case (port)
      south:   c.y = id.y - 1'b1;
      west:    c.x = id.x - 1'b1;
      north:   c.y = id.y + 1'b1;
      east:    c.x = id.x + 1'b1;
      default: c = id;
    endcase
    return c;
  endfunction

  function automatic int src_of(input xy_coord_t c);
    int found;
    found = -1;
    for (int p = 0; p < num_ports; p++) begin
      if (neighbour(port_idx_w'(p), xy_id) == c) begin
        found = p;
      end
    end
    return found;
  endfunction

  function automatic string test_name(input int unsigned id);
    case (id)
      1:       return "eject";
      2:       return "xy direction";
      3:       return "wormhole integrity";
      4:       return "contention";
      default: return "back-pressure";
    endcase
  endfunction

  function automatic logic drained();
    logic idle;
    idle = 1'b1;
    for (int p = 0; p < num_ports; p++) begin
      if (send_q[p].size() != 0) begin
        idle = 1'b0;
      end
    end
    for (int q = 0; q < num_ports * num_ports; q++) begin
      if (exp_q[q].size() != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic load_file(output logic ok);
    int          fd;
    int          n;
    int          cur_test;
    int          f_bp;
    int          f_x;
    int          f_y;
    int          f_src;
    int          f_len;
    int          f_exp;
    logic [31:0] f_base;
    string       line;
    packet_t     pkt;
    ok       = 1'b1;
    cur_test = 1;
    fd       = $fopen("tb/noc_router_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 1 && line.getc(0) == "r") begin
          n       = $sscanf(line, "router %d %d", f_x, f_y);
          xy_id.x = coord_w'(f_x);
          xy_id.y = coord_w'(f_y);
        end else if (n > 1 && line.getc(0) == "t") begin
          n                 = $sscanf(line, "test %d %d", cur_test, f_bp);
          test_bp[cur_test] = f_bp[0];
        end else if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %h %d", f_src, f_x, f_y, f_len, f_base, f_exp);
          if (n != 6) begin
            $display("Malformed packet line in the test data file: %s", line);
            ok = 1'b0;
          end else begin
            pkt.test_id  = 4'(cur_test);
            pkt.src_port = port_idx_w'(f_src);
            pkt.dst.x    = coord_w'(f_x);
            pkt.dst.y    = coord_w'(f_y);
            pkt.len      = 8'(f_len);
            pkt.base     = f_base;
            pkt.exp_port = port_idx_w'(f_exp);
            // Port listed in the file must agree with the XY rule
            check_value("expected port", 64'(f_exp), 64'(xy_route(pkt.dst, xy_id)));
            packets.push_back(pkt);
            flit_total += f_len;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic queue_packet(input packet_t pkt);
    flit_t       f;
    int unsigned src;
    src = 32'(pkt.src_port);
    for (int unsigned n = 0; n < 32'(pkt.len); n++) begin
      f.hdr.dst  = pkt.dst;
      f.hdr.src  = neighbour(pkt.src_port, xy_id);
      f.hdr.last = (n == 32'(pkt.len) - 1);
      f.payload  = pkt.base + n;
      send_q[src].push_back(f);
      exp_q[32'(pkt.exp_port) * num_ports + src].push_back(f);
    end
  endtask

  task automatic take_output(input int o, input flit_t f);
    int    src;
    int    idx;
    flit_t exp;
    flit_count++;
    src = src_of(f.hdr.src);
    if (src < 0) begin
      err_count++;
      $display("Output %0d delivered a flit from unknown source %h", o, f.hdr.src);
    end else begin
      if (cur_src[o] >= 0 && cur_src[o] != src) begin
        err_count++;
        $display("Output %0d put a flit from port %0d inside a packet from port %0d",
                 o, src, cur_src[o]);
      end
      idx = o * num_ports + src;
      if (exp_q[idx].size() == 0) begin
        err_count++;
        $display("Output %0d delivered an unexpected flit from port %0d", o, src);
      end else begin
        exp = exp_q[idx].pop_front();
        check_value($sformatf("out_flit_o[%0d]", o), 64'(f), 64'(exp));
      end
      cur_src[o] = f.hdr.last ? -1 : src;
    end
  endtask

  // Drive on the falling edge and sample halfway to the rising edge
  task automatic step_cycle(input logic random_ready, input logic send);
    @(negedge clk);
    for (int p = 0; p < num_ports; p++) begin
      if (random_ready) begin
        lfsr         = lfsr_next(lfsr);
        out_ready[p] = lfsr[0];
      end else begin
        out_ready[p] = 1'b1;
      end
      if (send && send_q[p].size() > 0) begin
        in_valid[p] = 1'b1;
        in_flit[p]  = send_q[p][0];
      end else begin
        in_valid[p] = 1'b0;
        in_flit[p]  = '0;
      end
    end
    #(half_period / 2);
    for (int p = 0; p < num_ports; p++) begin
      if (in_valid[p] && in_ready[p]) begin
        void'(send_q[p].pop_front());
      end
      if (out_valid[p] && out_ready[p]) begin
        take_output(p, out_flit[p]);
      end
    end
  endtask

  task automatic run_test(input int unsigned id);
    int unsigned errs_before;
    int unsigned flits_before;
    errs_before  = err_count;
    flits_before = flit_count;
    foreach (packets[k]) begin
      if (32'(packets[k].test_id) == id) begin
        queue_packet(packets[k]);
      end
    end
    while (!drained()) begin
      step_cycle(test_bp[id], 1'b1);
    end
    // Idle cycles expose duplicated flits
    repeat (8) begin
      step_cycle(1'b0, 1'b0);
    end
    for (int o = 0; o < num_ports; o++) begin
      if (cur_src[o] >= 0) begin
        err_count++;
        $display("Output %0d stopped before the last flit of a packet", o);
      end
    end
    check_value("out_valid_o", 64'(out_valid), 64'(0));
    $display("Test %0d %s: %0d flits, %0d errors", id, test_name(id),
             flit_count - flits_before, err_count - errs_before);
  endtask

  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with flits still undelivered", wd_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    logic ok;
    rst_n     = 1'b0;
    xy_id     = '0;
    in_flit   = '0;
    in_valid  = '0;
    out_ready = '0;
    for (int p = 0; p < num_ports; p++) begin
      cur_src[p] = -1;
    end
    for (int t = 0; t <= num_tests; t++) begin
      test_bp[t] = 1'b0;
    end
    load_file(ok);
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (!ok) begin
      $display("Test data could not be loaded");
      $display("TEST FAILED");
      $finish;
    end else begin
      wd_cycles = 32'(flit_total) * 20 + 200;
      for (int unsigned t = 1; t <= num_tests; t++) begin
        run_test(t);
      end
      $display("Summary: %0d tests, %0d packets, %0d flits, %0d checks, %0d errors",
               num_tests, packets.size(), flit_count, check_count, err_count);
      if (err_count == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

//--- src/noc_router.sv
/*
 * Five-port wormhole router for a 2D mesh with XY routing
 * One route selector per input feeding the crossbar
 */
module noc_router import noc_flit_pkg::*, noc_route_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  xy_coord_t                 xy_id_i,
  input  flit_t     [num_ports-1:0] in_flit_i,
  input  port_vec_t                 in_valid_i,
  output port_vec_t                 in_ready_o,
  output flit_t     [num_ports-1:0] out_flit_o,
  output port_vec_t                 out_valid_o,
  input  port_vec_t                 out_ready_i
);

  // One-hot output choice of every input
  port_vec_t [num_ports-1:0] route_sel;

  for (genvar p = 0; p < num_ports; p++) begin : gen_in
    route_select u_route_select (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .xy_id_i     (xy_id_i),
      .flit_i      (in_flit_i[p]),
      .valid_i     (in_valid_i[p]),
      .ready_i     (in_ready_o[p]),
      .route_sel_o (route_sel[p])
    );
  end

  router_crossbar u_crossbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_flit_i   (in_flit_i),
    .in_valid_i  (in_valid_i),
    .route_sel_i (route_sel),
    .in_ready_o  (in_ready_o),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

//--- src/router_crossbar.sv
/*
 * Router switch fabric
 * Per-output requests, flit multiplexers, arbiters and input ready
 */
module router_crossbar import noc_flit_pkg::*, noc_route_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  flit_t     [num_ports-1:0] in_flit_i,
  input  port_vec_t                 in_valid_i,
  input  port_vec_t [num_ports-1:0] route_sel_i,
  output port_vec_t                 in_ready_o,
  output flit_t     [num_ports-1:0] out_flit_o,
  output port_vec_t                 out_valid_o,
  input  port_vec_t                 out_ready_i
);

  // Indexed by output, then by input
  port_vec_t [num_ports-1:0] out_req;
  port_vec_t [num_ports-1:0] out_gnt;
  flit_t     [num_ports-1:0] out_sel_flit;
  port_vec_t                 out_accept;

  // Routes transposed into one request vector per output
  always_comb begin : proc_req
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        out_req[o][i] = in_valid_i[i] & route_sel_i[i][o];
      end
    end
  end

  // Grant is one-hot so at most one input drives each output
  always_comb begin : proc_flit_mux
    for (int o = 0; o < num_ports; o++) begin
      out_sel_flit[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        if (out_gnt[o][i]) begin
          out_sel_flit[o] = in_flit_i[i];
        end
      end
    end
  end

  // Input is ready when its output grants it and can take a flit
  always_comb begin : proc_ready
    for (int i = 0; i < num_ports; i++) begin
      in_ready_o[i] = 1'b0;
      for (int o = 0; o < num_ports; o++) begin
        if (route_sel_i[i][o] && out_gnt[o][i] && out_accept[o]) begin
          in_ready_o[i] = 1'b1;
        end
      end
    end
  end

  for (genvar p = 0; p < num_ports; p++) begin : gen_out
    output_arbiter u_arb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (out_req[p]),
      .flit_i      (out_sel_flit[p]),
      .out_ready_i (out_ready_i[p]),
      .gnt_o       (out_gnt[p]),
      .accept_o    (out_accept[p]),
      .out_flit_o  (out_flit_o[p]),
      .out_valid_o (out_valid_o[p])
    );
  end

endmodule

//--- src/output_arbiter.sv
/*
 * Round-robin arbiter for one router output
 * Grant held per packet, one-entry output register
 */
module output_arbiter import noc_flit_pkg::*, noc_route_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  port_vec_t req_i,
  input  flit_t     flit_i,
  input  logic      out_ready_i,
  output port_vec_t gnt_o,
  output logic      accept_o,
  output flit_t     out_flit_o,
  output logic      out_valid_o
);

  logic [port_idx_w-1:0] rr_q;
  logic [port_idx_w-1:0] rr_pick;
  logic [port_idx_w-1:0] rr_next;
  port_vec_t             rr_gnt;
  port_vec_t             gnt_q;
  port_vec_t             gnt;
  logic                  locked_q;
  logic                  fire;
  flit_t                 out_flit_q;
  logic                  out_valid_q;

  // First requester at or after the pointer wins
  always_comb begin : proc_rr_pick
    logic        found;
    int unsigned cand;
    found   = 1'b0;
    cand    = 0;
    rr_gnt  = '0;
    rr_pick = rr_q;
    for (int unsigned k = 0; k < num_ports; k++) begin
      cand = (32'(rr_q) + k) % num_ports;
      if (!found && req_i[cand]) begin
        found        = 1'b1;
        rr_gnt[cand] = 1'b1;
        rr_pick      = port_idx_w'(cand);
      end
    end
  end

  // Pointer moves to the port after the winner
  assign rr_next = (rr_pick == port_idx_w'(num_ports - 1)) ? '0 : rr_pick + 1'b1;

  // A packet in flight keeps its input
  assign gnt   = locked_q ? gnt_q : rr_gnt;
  assign gnt_o = gnt;

  // Register takes a flit when empty or draining this cycle
  assign accept_o = ~out_valid_q | out_ready_i;
  assign fire     = (|(req_i & gnt)) & accept_o;

  always_ff @(posedge clk_i) begin : proc_ctrl_ff
    if (!rst_n_i) begin
      locked_q    <= 1'b0;
      rr_q        <= '0;
      gnt_q       <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (fire) begin
        locked_q <= ~flit_i.hdr.last;
      end
      // Head flit or single-flit packet starts a new grant
      if (fire && !locked_q) begin
        rr_q  <= rr_next;
        gnt_q <= rr_gnt;
      end
      if (accept_o) begin
        out_valid_q <= fire;
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_data_ff
    if (fire) begin
      out_flit_q <= flit_i;
    end
  end

  assign out_flit_o  = out_flit_q;
  assign out_valid_o = out_valid_q;

endmodule

//--- src/route_select.sv
/*
 * XY route computation for one router input
 * The route is held for the whole of a multi-flit packet
 */
module route_select import noc_flit_pkg::*, noc_route_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  xy_coord_t xy_id_i,
  input  flit_t     flit_i,
  input  logic      valid_i,
  input  logic      ready_i,
  output port_vec_t route_sel_o
);

  xy_coord_t  dst;
  route_dir_e route_dir;
  port_vec_t  route_sel;
  port_vec_t  route_q;
  logic       locked_d;
  logic       locked_q;
  logic       handshake;

  assign dst       = flit_i.hdr.dst;
  assign handshake = valid_i & ready_i;

  // Dimension-ordered routing resolves x before y
  always_comb begin : proc_xy_dir
    if (dst == xy_id_i) begin
      route_dir = eject;
    end else if (dst.x == xy_id_i.x) begin
      if (dst.y < xy_id_i.y) begin
        route_dir = south;
      end else begin
        route_dir = north;
      end
    end else if (dst.x < xy_id_i.x) begin
      route_dir = west;
    end else begin
      route_dir = east;
    end
  end

  // Decode the direction into a one-hot port vector
  always_comb begin : proc_onehot
    route_sel            = '0;
    route_sel[route_dir] = 1'b1;
  end

  // Locked after an accepted non-last flit
  // Released again by the accepted last flit
  always_comb begin : proc_lock
    locked_d = locked_q;
    if (handshake) begin
      locked_d = ~flit_i.hdr.last;
    end
  end

  always_ff @(posedge clk_i) begin : proc_lock_ff
    if (!rst_n_i) begin
      locked_q <= 1'b0;
    end else begin
      locked_q <= locked_d;
    end
  end

  // Route of the head flit kept for the body flits
  always_ff @(posedge clk_i) begin : proc_route_ff
    if (!locked_q) begin
      route_q <= route_sel;
    end
  end

  // Body flits follow the stored route
  assign route_sel_o = locked_q ? route_q : route_sel;

endmodule

//--- src/noc_route_pkg.sv
/*
 * Router port numbering
 * Direction enum, port count and per-port bit vector
 */
package noc_route_pkg;

  // Local port plus the four mesh neighbours
  localparam int unsigned num_ports  = 5;
  localparam int unsigned port_idx_w = 3;

  // Port map, also the output picked by XY routing
  typedef enum logic [port_idx_w-1:0] {
    eject = 3'd0,  // Local node
    south = 3'd1,  // y decreasing
    west  = 3'd2,  // x decreasing
    north = 3'd3,  // y increasing
    east  = 3'd4   // x increasing
  } route_dir_e;

  // One bit per port, one-hot for routes and grants
  typedef logic [num_ports-1:0] port_vec_t;

endpackage

//--- src/noc_flit_pkg.sv
/*
 * Flit format of the mesh network
 * Coordinate, header and flit types with their field widths
 */
package noc_flit_pkg;

  // Width of one mesh coordinate
  localparam int unsigned coord_w   = 3;
  // Width of the data carried by each flit
  localparam int unsigned payload_w = 32;

  // Node position in the 2D mesh
  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } xy_coord_t;

  // Header sent along with every flit of a packet
  typedef struct packed {
    xy_coord_t dst;
    xy_coord_t src;
    logic      last;  // Set on the final flit only
  } flit_hdr_t;

  // Complete flit as it crosses a link
  typedef struct packed {
    flit_hdr_t            hdr;
    logic [payload_w-1:0] payload;
  } flit_t;

endpackage
